// ==== filelist.f ====
hdl/pd_pkg.sv
hdl/alu_ctl_if.sv
hdl/ir_reg.sv
hdl/instr_decoder.sv
hdl/alu_slice.sv
hdl/result_unit.sv
hdl/pd_top.sv
sim/tb_clock.sv
sim/pd_props.sv
sim/pd_tb.sv

// ==== hdl/alu_ctl_if.sv ====
// ALU and write-back control bundle
// Driven by the decoder, read by the ALU slices and the result unit

`timescale 1ns/1ps
`default_nettype none

interface alu_ctl_if;

	pd_pkg::alu_fn_e fn;	// Slice function select
	logic cin;				// Carry into the LSB slice
	logic wr_en;			// Write register A
	logic upd_zm;			// Update Z, M
	logic upd_vc;			// Update V, C
	logic upd_leg;			// Update L, E, G
	logic exec;				// W& step active

	modport ctl (
		output fn, cin, wr_en, upd_zm, upd_vc, upd_leg, exec
	);

	modport slice (
		input fn
	);

	modport result (
		input cin, wr_en, upd_zm, upd_vc, upd_leg, exec
	);

endinterface

`default_nettype wire

// ==== hdl/alu_slice.sv ====
// One ALU slice of SLICE_W bits
// Ripple-carry add/subtract plus the logic functions

`timescale 1ns/1ps
`default_nettype none

module alu_slice #(
	parameter int SLICE_W = 4
) (
	alu_ctl_if.slice ctl,
	input logic [0:SLICE_W-1] a,
	input logic [0:SLICE_W-1] b,
	input logic ci,					// From the less significant slice
	output logic [0:SLICE_W-1] f,
	output logic co					// To the more significant slice
);

	logic [0:SLICE_W-1] bx;		// b, inverted for subtract
	logic [0:SLICE_W-1] sum;
	logic [0:SLICE_W] c;		// c[i] is the carry out of bit i

	assign bx = (ctl.fn == pd_pkg::FN_SUB) ? ~b : b;
	assign c[SLICE_W] = ci;

	// Bit SLICE_W-1 is the slice LSB, carry runs toward bit 0
	for (genvar i = 0; i < SLICE_W; i++) begin : g_bit
		assign sum[i] = a[i] ^ bx[i] ^ c[i+1];
		assign c[i] = (a[i] & bx[i]) | (c[i+1] & (a[i] ^ bx[i]));
	end

	always_comb begin
		co = ci;	// Logic ops just pass the chain through
		case (ctl.fn)
			pd_pkg::FN_PASS_B: f = b;
			pd_pkg::FN_ADD, pd_pkg::FN_SUB: begin
				f = sum;
				co = c[0];
			end
			pd_pkg::FN_OR: f = a | b;
			pd_pkg::FN_AND: f = a & b;
			pd_pkg::FN_ANDN: f = a & ~b;
			pd_pkg::FN_XOR: f = a ^ b;
			default: f = b;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/instr_decoder.sv ====
// Instruction decoder
// Opcode to ALU function and flag groups, legality check,
// phase sequencer and ekc/xi end-of-cycle pulses

`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
	input logic strob1,
	input logic rst,
	input logic [0:pd_pkg::WORD_W-1] ir,
	input logic [0:2] w_c,			// C field of the word on the bus
	input logic w_ir,
	input logic w_arg,
	input logic flag_c,				// R0 C flag, carry in for AC
	output logic arg_load,
	output logic ir_load,
	alu_ctl_if.ctl ctl,
	output logic [0:2] reg_a,
	output logic [0:2] reg_c,
	output logic use_arg,
	output logic ekc,
	output logic xi
);

	pd_pkg::phase_e phase;
	pd_pkg::opcode_e op;
	pd_pkg::alu_fn_e fn_sel;
	logic cin_sel;
	logic known;			// Opcode in the supported set
	logic legal;
	logic exec;
	logic wr_op;
	logic zm_op;
	logic vc_op;
	logic leg_op;

	assign op = pd_pkg::opcode_e'(ir[0:5]);
	assign reg_a = ir[7:9];
	assign reg_c = ir[13:15];
	assign use_arg = (reg_c == 3'd0);	// C=0, argument in next word

	always_comb begin
		known = 1'b1;
		fn_sel = pd_pkg::FN_PASS_B;
		cin_sel = 1'b0;
		wr_op = 1'b1;
		zm_op = 1'b1;
		vc_op = 1'b0;
		leg_op = 1'b0;
		case (op)
			pd_pkg::OP_LW: begin
				zm_op = 1'b0;			// Plain move, flags kept
			end
			pd_pkg::OP_AW: begin
				fn_sel = pd_pkg::FN_ADD;
				vc_op = 1'b1;
			end
			pd_pkg::OP_AC: begin
				fn_sel = pd_pkg::FN_ADD;
				cin_sel = flag_c;		// Chained add
				vc_op = 1'b1;
			end
			pd_pkg::OP_SW: begin
				fn_sel = pd_pkg::FN_SUB;
				cin_sel = 1'b1;			// Two's complement of argument
				vc_op = 1'b1;
			end
			pd_pkg::OP_CW: begin
				fn_sel = pd_pkg::FN_SUB;
				cin_sel = 1'b1;
				wr_op = 1'b0;			// Compare only
				zm_op = 1'b0;
				leg_op = 1'b1;
			end
			pd_pkg::OP_OR: fn_sel = pd_pkg::FN_OR;
			pd_pkg::OP_NR: fn_sel = pd_pkg::FN_AND;
			pd_pkg::OP_ER: fn_sel = pd_pkg::FN_ANDN;
			pd_pkg::OP_XR: fn_sel = pd_pkg::FN_XOR;
			default: begin
				known = 1'b0;
				wr_op = 1'b0;
				zm_op = 1'b0;
			end
		endcase
	end

	// B-modification and R0 as target are not handled
	assign legal = known & (ir[10:12] == 3'd0) & (reg_a != 3'd0);
	assign exec = (phase == pd_pkg::PH_EXEC);

	assign ir_load = (phase == pd_pkg::PH_IDLE) & w_ir;
	assign arg_load = (phase == pd_pkg::PH_ARG) & w_arg;

	assign ctl.fn = fn_sel;
	assign ctl.cin = cin_sel;
	assign ctl.exec = exec;
	assign ctl.wr_en = legal & wr_op;	// Illegal instruction writes nothing
	assign ctl.upd_zm = legal & zm_op;
	assign ctl.upd_vc = legal & vc_op;
	assign ctl.upd_leg = legal & leg_op;

	always_ff @(posedge strob1) begin
		if (rst) begin
			phase <= pd_pkg::PH_IDLE;
			ekc <= 1'b0;
			xi <= 1'b0;
		end else begin
			ekc <= exec & legal;		// One pulse per finished instruction
			xi <= exec & ~legal;
			case (phase)
				pd_pkg::PH_IDLE: begin
					if (w_ir) begin
						phase <= (w_c != 3'd0) ? pd_pkg::PH_EXEC : pd_pkg::PH_ARG;
					end
				end
				pd_pkg::PH_ARG: begin
					if (w_arg) begin
						phase <= pd_pkg::PH_EXEC;
					end
				end
				pd_pkg::PH_EXEC: phase <= pd_pkg::PH_IDLE;
				default: phase <= pd_pkg::PH_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/ir_reg.sv ====
// Instruction register
// Loads on strobe, si1 clears the two opcode MSBs at load

`timescale 1ns/1ps
`default_nettype none

module ir_reg (
	input logic strob1,
	input logic rst,
	input logic load,		// W->IR
	input logic invalidate,	// si1
	input logic [0:pd_pkg::WORD_W-1] d,
	output logic [0:pd_pkg::WORD_W-1] q
);

	always_ff @(posedge strob1) begin
		if (rst) begin
			q <= '0;
		end else if (load) begin
			q <= d;
			// Zeroed opcode MSBs disable the decoder, instruction becomes illegal
			if (invalidate) begin
				q[0:1] <= 2'b00;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/pd_pkg.sv ====
// Shared definitions for the P-D decode and execute slice
// Word width, opcode and ALU function enums, phase enum, R0 flag indices

`default_nettype none

package pd_pkg;

	localparam int WORD_W = 16;	// One machine word, bit 0 is the MSB

	// Two-argument opcodes handled here, octal as in the manual
	typedef enum logic [5:0] {
		OP_LW = 6'o20,	// Load word
		OP_AW = 6'o40,	// Add word
		OP_AC = 6'o41,	// Add with carry
		OP_SW = 6'o42,	// Subtract word
		OP_CW = 6'o43,	// Compare word
		OP_OR = 6'o44,	// Logical or
		OP_NR = 6'o46,	// Logical and
		OP_ER = 6'o50,	// Erase bits (and not)
		OP_XR = 6'o52	// Exclusive or
	} opcode_e;

	typedef enum logic [2:0] {
		FN_PASS_B,	// f = b
		FN_ADD,		// f = a + b + ci
		FN_SUB,		// f = a + ~b + ci
		FN_OR,
		FN_AND,
		FN_ANDN,	// f = a & ~b
		FN_XOR
	} alu_fn_e;

	typedef enum logic [1:0] {
		PH_IDLE,	// Waiting for W->IR
		PH_ARG,		// Waiting for the argument word
		PH_EXEC		// W& step, write-back
	} phase_e;

	// R0 flag bit positions
	localparam int R0_Z = 0;
	localparam int R0_M = 1;
	localparam int R0_V = 2;
	localparam int R0_C = 3;
	localparam int R0_L = 4;
	localparam int R0_E = 5;
	localparam int R0_G = 6;

endpackage

`default_nettype wire

// ==== hdl/pd_top.sv ====
// Top level of the decode and execute slice
// IR, decoder, generated ALU slices and the result unit

`timescale 1ns/1ps
`default_nettype none

module pd_top #(
	parameter int SLICE_W = 4
) (
	input logic strob1,
	input logic rst,
	input logic [0:15] w,		// W bus
	input logic w_ir,			// W->IR
	input logic w_arg,			// W->argument latch
	input logic si1,
	input logic [0:2] rd_sel,
	output logic [0:15] ir,
	output logic [0:8] r0,
	output logic [0:15] rd_data,
	output logic ekc,			// Cycle end
	output logic xi				// Illegal instruction
);

	localparam int N_SLICE = pd_pkg::WORD_W / SLICE_W;

	alu_ctl_if ctl_bus();

	logic ir_load;
	logic arg_load;
	logic use_arg;
	logic flag_c;
	logic alu_co;
	logic [0:2] reg_a;
	logic [0:2] reg_c;
	logic [0:pd_pkg::WORD_W-1] op_a;
	logic [0:pd_pkg::WORD_W-1] op_b;
	logic [0:pd_pkg::WORD_W-1] alu_f;
	logic [0:N_SLICE] carry;	// carry[i] leaves slice i

	ir_reg u_ir (
		.strob1(strob1),
		.rst(rst),
		.load(ir_load),
		.invalidate(si1),
		.d(w),
		.q(ir)
	);

	instr_decoder u_dec (
		.strob1(strob1),
		.rst(rst),
		.ir(ir),
		.w_c(w[13:15]),		// Selects PH_ARG or PH_EXEC at load
		.w_ir(w_ir),
		.w_arg(w_arg),
		.flag_c(flag_c),
		.arg_load(arg_load),
		.ir_load(ir_load),
		.ctl(ctl_bus.ctl),
		.reg_a(reg_a),
		.reg_c(reg_c),
		.use_arg(use_arg),
		.ekc(ekc),
		.xi(xi)
	);

	result_unit u_res (
		.strob1(strob1),
		.rst(rst),
		.ctl(ctl_bus.result),
		.reg_a(reg_a),
		.reg_c(reg_c),
		.use_arg(use_arg),
		.arg_load(arg_load),
		.w(w),
		.alu_f(alu_f),
		.alu_co(alu_co),
		.op_a(op_a),
		.op_b(op_b),
		.flag_c(flag_c),
		.r0(r0),
		.rd_sel(rd_sel),
		.rd_data(rd_data)
	);

	assign carry[N_SLICE] = ctl_bus.cin;	// Enters the LSB slice
	assign alu_co = carry[0];

	// Slice 0 holds the MSBs
	for (genvar i = 0; i < N_SLICE; i++) begin : g_slice
		alu_slice #(
			.SLICE_W(SLICE_W)
		) u_slice (
			.ctl(ctl_bus.slice),
			.a(op_a[i*SLICE_W +: SLICE_W]),
			.b(op_b[i*SLICE_W +: SLICE_W]),
			.ci(carry[i+1]),
			.f(alu_f[i*SLICE_W +: SLICE_W]),
			.co(carry[i])
		);
	end

endmodule

`default_nettype wire

// ==== hdl/result_unit.sv ====
// Result unit
// User registers R1..R7, R0 flags, argument latch,
// operand select, write-back and flag computation

`timescale 1ns/1ps
`default_nettype none

module result_unit (
	input logic strob1,
	input logic rst,
	alu_ctl_if.result ctl,
	input logic [0:2] reg_a,
	input logic [0:2] reg_c,
	input logic use_arg,
	input logic arg_load,
	input logic [0:pd_pkg::WORD_W-1] w,
	input logic [0:pd_pkg::WORD_W-1] alu_f,
	input logic alu_co,
	output logic [0:pd_pkg::WORD_W-1] op_a,
	output logic [0:pd_pkg::WORD_W-1] op_b,
	output logic flag_c,
	output logic [0:8] r0,
	input logic [0:2] rd_sel,
	output logic [0:pd_pkg::WORD_W-1] rd_data
);

	localparam int LSB = pd_pkg::WORD_W - 1;

	logic [0:pd_pkg::WORD_W-1] regs [1:7];	// R1..R7
	logic [0:pd_pkg::WORD_W-1] arg_q;		// Argument word from the bus
	logic is_sub;
	logic ovf;
	logic res_zero;

	function automatic logic [0:pd_pkg::WORD_W-1] rd_reg(input logic [0:2] sel);
		if (sel == 3'd0) begin
			return '0;
		end
		return regs[sel];
	endfunction

	always_comb begin
		op_a = rd_reg(reg_a);
		op_b = use_arg ? arg_q : rd_reg(reg_c);
		rd_data = (rd_sel == 3'd0) ? {7'd0, r0} : rd_reg(rd_sel);
	end

	assign flag_c = r0[pd_pkg::R0_C];
	assign res_zero = (alu_f == '0);

	// With cin set, an add flips the LSB parity and a subtract does not
	assign is_sub = ctl.cin & (alu_f[LSB] == (op_a[LSB] ^ op_b[LSB]));
	// Signs agree (after inversion) and the result sign differs
	assign ovf = ((op_b[0] ^ is_sub) == op_a[0]) & (alu_f[0] != op_a[0]);

	always_ff @(posedge strob1) begin
		if (arg_load) begin
			arg_q <= w;
		end
	end

	always_ff @(posedge strob1) begin
		if (rst) begin
			for (int i = 1; i <= 7; i++) begin
				regs[i] <= '0;
			end
			r0 <= '0;
		end else if (ctl.exec) begin
			if (ctl.wr_en) begin
				regs[reg_a] <= alu_f;
			end
			if (ctl.upd_zm) begin
				r0[pd_pkg::R0_Z] <= res_zero;
				r0[pd_pkg::R0_M] <= alu_f[0];	// Sign of result
			end
			if (ctl.upd_vc) begin
				r0[pd_pkg::R0_V] <= ovf;
				r0[pd_pkg::R0_C] <= alu_co;
			end
			if (ctl.upd_leg) begin
				// Signed less: difference sign corrected by overflow
				r0[pd_pkg::R0_L] <= alu_f[0] ^ ovf;
				r0[pd_pkg::R0_E] <= res_zero;
				r0[pd_pkg::R0_G] <= ~(alu_f[0] ^ ovf) & ~res_zero;
			end
		end
	end

endmodule

`default_nettype wire

// ==== sim/pd_props.sv ====
// Concurrent checks on the ekc/xi end-of-instruction pulses
// Module pd_props and its bind into pd_top

`timescale 1ns/1ps
`default_nettype none

module pd_props (
	input logic strob1,
	input logic rst,
	input logic [0:15] w,
	input logic w_ir,
	input pd_pkg::phase_e phase,	// Decoder sequencer state
	input logic ekc,
	input logic xi
);

	int fail_cnt = 0;	// Failed assertion count

	a_excl: assert property (@(posedge strob1) disable iff (rst) !(ekc && xi))
		else begin
			$error("ekc and xi high in the same cycle");
			fail_cnt++;
		end

	a_ekc_pulse: assert property (@(posedge strob1) disable iff (rst) ekc |=> !ekc)
		else begin
			$error("ekc held longer than one cycle");
			fail_cnt++;
		end

	a_xi_pulse: assert property (@(posedge strob1) disable iff (rst) xi |=> !xi)
		else begin
			$error("xi held longer than one cycle");
			fail_cnt++;
		end

	// Register argument, load edge then W& edge
	a_reg_latency: assert property (@(posedge strob1) disable iff (rst)
		(phase == pd_pkg::PH_IDLE && w_ir && w[13:15] != 3'd0)
		|=> !(ekc || xi) ##1 (ekc || xi))
		else begin
			$error("ekc or xi not two edges after a register-argument load");
			fail_cnt++;
		end

endmodule

bind pd_top pd_props u_props (
	.strob1(strob1),
	.rst(rst),
	.w(w),
	.w_ir(w_ir),
	.phase(u_dec.phase),
	.ekc(ekc),
	.xi(xi)
);

`default_nettype wire

// ==== sim/pd_tb.sv ====
// Directed testbench for pd_top
// Reference model of registers and R0 flags, LFSR operands,
// instruction driver tasks, one task per test, timeout and summary

`timescale 1ns/1ps
`default_nettype none

module pd_tb;

	localparam int N_INSTR = 98;	// 9 load, 40 arith, 27 logic, 16 compare, 4 illegal, 2 ignore
	localparam int LIMIT = 5 + N_INSTR * 20 + 4 * 9 + 4;	// Reset, instructions, scans, strays

	logic strob1;
	logic rst;
	logic [0:15] w;
	logic w_ir;
	logic w_arg;
	logic si1;
	logic [0:2] rd_sel;
	logic [0:15] ir;
	logic [0:8] r0;
	logic [0:15] rd_data;
	logic ekc;
	logic xi;

	logic [15:0] m_reg [0:7];	// Model R1..R7 with entry 0 unused
	logic [0:8] m_r0;			// Model flags
	logic [31:0] lfsr_state;
	int err_count = 0;
	int n_checks = 0;
	int n_tests = 0;
	int cycle_cnt = 0;

	tb_clock #(.PERIOD(100)) u_clk (.clk(strob1));

	pd_top #(.SLICE_W(4)) DUT (
		.strob1(strob1), .rst(rst), .w(w), .w_ir(w_ir), .w_arg(w_arg), .si1(si1),
		.rd_sel(rd_sel), .ir(ir), .r0(r0), .rd_data(rd_data), .ekc(ekc), .xi(xi)
	);

	always @(posedge strob1) begin
		cycle_cnt++;
		if (cycle_cnt >= LIMIT) begin
			$display("Timeout: run still going after %0d cycles", LIMIT);
			$display("Regression failed");
			$finish;
		end
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_word(output logic [15:0] v);
		v = '0;
		for (int k = 0; k < 16; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[14:0], lfsr_state[0]};	// One step per bit
		end
	endtask

	function automatic logic [15:0] exp_read(input logic [2:0] sel);
		if (sel == 3'd0) begin
			return {7'd0, m_r0};	// R0 zero-extended
		end
		return m_reg[sel];
	endfunction

	task automatic model_exec(input logic [5:0] op, input logic [2:0] a, input logic [2:0] c,
			input logic [15:0] arg);
		logic [15:0] x;
		logic [15:0] y;
		logic [16:0] s;
		x = m_reg[a];
		y = (c == 3'd0) ? arg : m_reg[c];
		s = '0;
		case (op)
			pd_pkg::OP_LW: m_reg[a] = y;	// No flags
			pd_pkg::OP_AW: s = {1'b0, x} + {1'b0, y};
			pd_pkg::OP_AC: s = {1'b0, x} + {1'b0, y} + {16'd0, m_r0[pd_pkg::R0_C]};
			pd_pkg::OP_SW: s = {1'b0, x} + {1'b0, ~y} + 17'd1;
			pd_pkg::OP_CW: begin
				m_r0[pd_pkg::R0_L] = $signed(x) < $signed(y);
				m_r0[pd_pkg::R0_E] = (x == y);
				m_r0[pd_pkg::R0_G] = $signed(x) > $signed(y);
			end
			pd_pkg::OP_OR: s[15:0] = x | y;
			pd_pkg::OP_NR: s[15:0] = x & y;
			pd_pkg::OP_ER: s[15:0] = x & ~y;
			default: s[15:0] = x ^ y;	// XR
		endcase
		if (op == pd_pkg::OP_AW || op == pd_pkg::OP_AC || op == pd_pkg::OP_SW) begin
			m_r0[pd_pkg::R0_C] = s[16];
			// Signs agree, argument inverted for SW, and result sign differs
			m_r0[pd_pkg::R0_V] = (x[15] == ((op == pd_pkg::OP_SW) ? ~y[15] : y[15]))
				&& (s[15] != x[15]);
		end
		if (op != pd_pkg::OP_LW && op != pd_pkg::OP_CW) begin
			m_reg[a] = s[15:0];
			m_r0[pd_pkg::R0_Z] = (s[15:0] == 16'd0);
			m_r0[pd_pkg::R0_M] = s[15];	// Sign bit
		end
	endtask

	// Load, optional stray w_ir pulses and argument, then wait for ekc or xi
	task automatic run_instr(input logic [5:0] op, input logic [2:0] a, input logic [2:0] b,
			input logic [2:0] c, input logic [15:0] arg, input logic inval,
			input logic expect_xi, input int stray);
		logic [15:0] instr;
		int n;
		instr = {op, 1'b0, a, b, c};
		@(negedge strob1);
		w = instr;
		w_ir = 1'b1;
		si1 = inval;
		rd_sel = a;
		@(negedge strob1);
		w_ir = 1'b0;
		si1 = 1'b0;
		if (c == 3'd0) begin
			for (int k = 0; k < stray; k++) begin
				w = {pd_pkg::OP_XR, 1'b0, 3'd1, 3'd0, 3'd2};	// Must be ignored in PH_ARG
				w_ir = 1'b1;
				@(negedge strob1);
				w_ir = 1'b0;
				@(negedge strob1);
				n_checks++;
				assert (ir == instr) else begin
					$display("[FAIL] %0t ns: IR changed to %h by a w_ir pulse", $time, ir);
					err_count++;
				end
			end
			w = arg;
			w_arg = 1'b1;
			@(negedge strob1);
			w_arg = 1'b0;
		end
		n = 0;
		while (!ekc && !xi && n < 20) begin
			@(negedge strob1);
			n++;
		end
		if (!ekc && !xi) begin
			$display("Instruction %o gave no ekc or xi within 20 cycles", instr);
			err_count++;
		end else begin
			if (!expect_xi) begin
				model_exec(op, a, c, arg);
			end
			n_checks += 3;
			assert (ekc == !expect_xi && xi == expect_xi) else begin
				$display("[FAIL] %0t ns: instruction %o ended with ekc=%b xi=%b",
					$time, instr, ekc, xi);
				err_count++;
			end
			assert (rd_data == exp_read(a)) else begin
				$display("[FAIL] %0t ns: R%0d is %h, expected %h", $time, a, rd_data,
					exp_read(a));
				err_count++;
			end
			assert (r0 == m_r0) else begin
				$display("[FAIL] %0t ns: R0 flags %b, expected %b", $time, r0, m_r0);
				err_count++;
			end
		end
	endtask

	task automatic lw_arg(input logic [2:0] a, input logic [15:0] v);
		run_instr(pd_pkg::OP_LW, a, 3'd0, 3'd0, v, 1'b0, 1'b0, 0);
	endtask

	task automatic op_reg(input logic [5:0] op, input logic [2:0] a, input logic [2:0] c);
		run_instr(op, a, 3'd0, c, 16'd0, 1'b0, 1'b0, 0);
	endtask

	task automatic op_arg(input logic [5:0] op, input logic [2:0] a, input logic [15:0] v);
		run_instr(op, a, 3'd0, 3'd0, v, 1'b0, 1'b0, 0);
	endtask

	// Read back R0..R7 one per cycle
	task automatic scan_regs();
		@(negedge strob1);
		rd_sel = 3'd0;
		for (int i = 1; i <= 8; i++) begin
			@(negedge strob1);
			n_checks++;
			assert (rd_data == exp_read(3'(i - 1))) else begin
				$display("[FAIL] %0t ns: read of R%0d gave %h, expected %h", $time, i - 1,
					rd_data, exp_read(3'(i - 1)));
				err_count++;
			end
			if (i < 8) begin
				rd_sel = 3'(i);
			end
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		n_tests++;
		if (err_count == err_before) begin
			$display("%-12s ok", name);
		end else begin
			$display("%-12s %0d errors", name, err_count - err_before);
		end
	endtask

	task automatic test_load();
		logic [15:0] v;
		int e0;
		e0 = err_count;
		for (int r = 1; r <= 7; r++) begin
			rand_word(v);
			lw_arg(3'(r), v);
		end
		scan_regs();
		op_reg(pd_pkg::OP_LW, 3'd1, 3'd3);	// Register copies
		op_reg(pd_pkg::OP_LW, 3'd5, 3'd7);
		scan_regs();
		report_test("load", e0);
	endtask

	task automatic test_arith();
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] s;
		int e0;
		e0 = err_count;
		for (int i = 0; i < 8; i++) begin
			if (i == 0) begin
				a = 16'h7fff;	// Positive overflow
				b = 16'h0001;
			end else if (i == 1) begin
				a = 16'h8000;	// Zero result with carry and overflow
				b = 16'h8000;
			end else begin
				rand_word(a);
				rand_word(b);
			end
			rand_word(s);
			lw_arg(3'd1, a);
			lw_arg(3'd2, b);
			op_reg(pd_pkg::OP_AW, 3'd1, 3'd2);
			op_reg(pd_pkg::OP_AC, 3'd1, 3'd2);	// Carry from the AW
			op_arg(pd_pkg::OP_SW, 3'd1, s);
		end
		report_test("arith", e0);
	endtask

	task automatic test_logic();
		logic [5:0] lops [0:3] = '{pd_pkg::OP_OR, pd_pkg::OP_NR, pd_pkg::OP_ER, pd_pkg::OP_XR};
		logic [15:0] a;
		logic [15:0] b;
		int e0;
		e0 = err_count;
		for (int i = 0; i < 3; i++) begin
			rand_word(a);
			rand_word(b);
			if (i == 0) begin
				b = a;	// ER and XR give zero
			end
			lw_arg(3'd5, b);
			for (int k = 0; k < 4; k++) begin
				lw_arg(3'd4, a);
				op_reg(lops[k], 3'd4, 3'd5);
			end
		end
		report_test("logic", e0);
	endtask

	task automatic test_compare();
		logic [15:0] ca [0:7] = '{16'd5, 16'd1, 16'd2, 16'h8000, 16'd1, 16'h7fff, 16'd0, 16'd0};
		logic [15:0] cb [0:7] = '{16'd5, 16'd2, 16'd1, 16'd1, 16'hffff, 16'h8000, 16'd0, 16'd0};
		int e0;
		e0 = err_count;
		rand_word(ca[6]);
		rand_word(cb[6]);
		rand_word(ca[7]);
		cb[7] = ca[7];
		for (int i = 0; i < 8; i++) begin
			lw_arg(3'd6, ca[i]);
			op_arg(pd_pkg::OP_CW, 3'd6, cb[i]);
			n_checks++;
			assert (r0[pd_pkg::R0_L] + r0[pd_pkg::R0_E] + r0[pd_pkg::R0_G] == 2'd1) else begin
				$display("[FAIL] %0t ns: L E G = %b %b %b, not exactly one set", $time,
					r0[pd_pkg::R0_L], r0[pd_pkg::R0_E], r0[pd_pkg::R0_G]);
				err_count++;
			end
		end
		scan_regs();
		report_test("compare", e0);
	endtask

	task automatic test_illegal();
		int e0;
		e0 = err_count;
		run_instr(6'o21, 3'd3, 3'd0, 3'd4, 16'd0, 1'b0, 1'b1, 0);	// Unknown opcode
		run_instr(pd_pkg::OP_AW, 3'd3, 3'd1, 3'd4, 16'd0, 1'b0, 1'b1, 0);	// B modifier
		run_instr(pd_pkg::OP_AW, 3'd0, 3'd0, 3'd4, 16'd0, 1'b0, 1'b1, 0);	// Target R0
		run_instr(pd_pkg::OP_LW, 3'd3, 3'd0, 3'd4, 16'd0, 1'b1, 1'b1, 0);	// si1 at load
		n_checks++;
		assert (ir[0:1] == 2'b00) else begin
			$display("[FAIL] %0t ns: IR bits 0:1 are %b after si1 load", $time, ir[0:1]);
			err_count++;
		end
		scan_regs();
		report_test("illegal", e0);
	endtask

	task automatic test_arg_ignore();
		logic [15:0] v;
		int e0;
		e0 = err_count;
		rand_word(v);
		run_instr(pd_pkg::OP_LW, 3'd7, 3'd0, 3'd0, v, 1'b0, 1'b0, 2);
		op_reg(pd_pkg::OP_AW, 3'd7, 3'd1);	// Runs normally afterwards
		report_test("arg_ignore", e0);
	endtask

	initial begin
		rst = 1'b1;
		w = '0;
		w_ir = 1'b0;
		w_arg = 1'b0;
		si1 = 1'b0;
		rd_sel = 3'd0;
		lfsr_state = 32'hfd425afd;
		m_r0 = '0;
		for (int i = 0; i < 8; i++) begin
			m_reg[i] = 16'd0;
		end
		repeat (5) @(posedge strob1);	// Five reset edges
		@(negedge strob1);
		rst = 1'b0;
		test_load();
		test_arith();
		test_logic();
		test_compare();
		test_illegal();
		test_arg_ignore();
		err_count += DUT.u_props.fail_cnt;	// Concurrent assertion failures
		$display("Summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, err_count);
		if (err_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/tb_clock.sv ====
// Testbench clock generator
// Free-running, 100 ns period, starts low

`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 100
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;	// Half period per toggle
	end

endmodule

`default_nettype wire
